// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = graph_column_tb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/plot_pkg.sv
package plot_pkg;

    // fixed point format
    localparam int int_width    = 12;
    localparam int frac_width   = 8;
    localparam int number_width = int_width + frac_width;

    typedef logic signed [number_width-1:0] fixed_t;

    // top bit flags an operator, otherwise the low bits are a constant
    typedef logic [number_width:0] token_t;
    typedef logic [2:0]            op_t;

    localparam op_t op_add = 3'd0;
    localparam op_t op_sub = 3'd1;
    localparam op_t op_mul = 3'd2;
    localparam op_t op_div = 3'd3;
    localparam op_t op_pow = 3'd4;
    localparam op_t op_var = 3'd6;

    localparam int queue_size = 32;
    typedef logic [$clog2(queue_size)-1:0] queue_index_t;
    typedef logic [$clog2(queue_size+1)-1:0] queue_len_t;

    // one entry per token at most, so the stack cannot overflow
    localparam int stack_size = queue_size;
    typedef logic [$clog2(stack_size)-1:0] stack_index_t;
    typedef logic [$clog2(stack_size):0] stack_ptr_t;

    // screen
    localparam int hor_active = 640;
    localparam int ver_active = 480;
    typedef logic [$clog2(hor_active)-1:0] col_t;
    typedef logic [$clog2(ver_active)-1:0] row_t;

    localparam int scale = 20;

    localparam fixed_t fixed_one   = fixed_t'(1 << frac_width);
    localparam fixed_t x_center    = fixed_t'((hor_active / 2) << frac_width);
    localparam fixed_t y_center    = fixed_t'((ver_active / 2) << frac_width);
    localparam fixed_t scale_fixed = fixed_t'(scale << frac_width);

endpackage

// File: design/graph_column_top.sv
`timescale 1ns/1ps

module graph_column_top import plot_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   clear,
    input  logic   load_en,
    input  token_t load_data,
    input  logic   start,
    input  col_t   x,
    output logic   ready,
    output row_t   row,
    output logic   skip
);

    queue_len_t   queue_length;
    logic         queue_get;
    queue_index_t queue_index;
    logic         queue_ready;
    token_t       queue_data;

    token_queue queue (
        .clk          (clk),
        .arst_n       (arst_n),
        .clear        (clear),
        .load_en      (load_en),
        .load_data    (load_data),
        .queue_get    (queue_get),
        .queue_index  (queue_index),
        .queue_length (queue_length),
        .queue_ready  (queue_ready),
        .queue_data   (queue_data)
    );

    stack_machine machine (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .x            (x),
        .queue_length (queue_length),
        .queue_ready  (queue_ready),
        .queue_data   (queue_data),
        .ready        (ready),
        .row          (row),
        .skip         (skip),
        .queue_get    (queue_get),
        .queue_index  (queue_index)
    );

endmodule

// File: design/token_queue.sv
`timescale 1ns/1ps

module token_queue import plot_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         clear,
    input  logic         load_en,
    input  token_t       load_data,
    input  logic         queue_get,
    input  queue_index_t queue_index,
    output queue_len_t   queue_length,
    output logic         queue_ready,
    output token_t       queue_data
);

    token_t     mem [queue_size];
    queue_len_t wr_ptr;
    logic       full;
    logic       write_en;

    assign full         = (wr_ptr == queue_len_t'(queue_size));
    assign write_en     = load_en && !clear && !full;
    assign queue_length = wr_ptr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            queue_ready <= 1'b0;
        end else begin
            queue_ready <= queue_get;
            if (clear) begin
                wr_ptr <= '0;
            end else if (write_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // tokens offered when full are dropped
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[queue_index_t'(wr_ptr)] <= load_data;
        end
        if (queue_get) begin
            queue_data <= mem[queue_index];
        end
    end

endmodule

// File: sources.f
common/plot_pkg.sv
design/token_queue.sv
stack_machine/fixed_point_alu.sv
stack_machine/stack_machine.sv
design/graph_column_top.sv
tests/graph_column_tb.sv

// File: stack_machine/fixed_point_alu.sv
`timescale 1ns/1ps

module fixed_point_alu import plot_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    input  op_t    op,
    input  fixed_t a,
    input  fixed_t b,
    output logic   done,
    output fixed_t result
);

    typedef enum logic [2:0] {
        s_idle,
        s_mul,
        s_pow,
        s_div,
        s_div_fix
    } state_t;

    state_t state;

    logic signed [2*number_width-1:0] product;
    fixed_t                           base;
    fixed_t                           mul_rhs;
    logic [int_width-1:0]             steps;
    logic [int_width-1:0]             exponent;

    logic [number_width-1:0] mag_a;
    logic [number_width-1:0] mag_b;
    logic [number_width-1:0] pre_rem;
    logic [number_width:0]   pre_step;
    logic [number_width-1:0] rem;
    logic [number_width-1:0] dividend;
    logic [number_width-1:0] divisor;
    logic [number_width-1:0] quot;
    logic [number_width:0]   div_next;
    logic                    negate;

    // one restoring step, returns {quotient bit, new remainder}
    function automatic logic [number_width:0] div_step(
        input logic [number_width-1:0] rem_in,
        input logic                    bit_in,
        input logic [number_width-1:0] div_in
    );
        logic [number_width-1:0] shifted;
        shifted = {rem_in[number_width-2:0], bit_in};
        if (shifted >= div_in) begin
            return {1'b1, shifted - div_in};
        end
        return {1'b0, shifted};
    endfunction

    always_comb begin
        mag_a    = a[number_width-1] ? -a : a;
        mag_b    = b[number_width-1] ? -b : b;
        mul_rhs  = (op == op_pow) ? fixed_one : b;
        exponent = b[number_width-1] ? '0 : b[number_width-1:frac_width];
        // the top dividend bits are consumed in the load cycle
        pre_rem  = '0;
        pre_step = '0;
        for (int i = number_width - 1; i >= number_width - frac_width; i--) begin
            pre_step = div_step(pre_rem, mag_a[i], mag_b);
            pre_rem  = pre_step[number_width-1:0];
        end
        div_next = div_step(rem, dividend[number_width-1], divisor);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= s_idle;
            done     <= 1'b0;
            result   <= '0;
            product  <= '0;
            base     <= '0;
            steps    <= '0;
            rem      <= '0;
            dividend <= '0;
            divisor  <= '0;
            quot     <= '0;
            negate   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        case (op)
                            op_add: begin
                                result <= a + b;
                                done   <= 1'b1;
                            end
                            op_sub: begin
                                result <= a - b;
                                done   <= 1'b1;
                            end
                            op_mul, op_pow: begin
                                if (op == op_pow && exponent == '0) begin
                                    result <= fixed_one;
                                    done   <= 1'b1;
                                end else begin
                                    // power starts from 1.0 times a
                                    product <= a * mul_rhs;
                                    base    <= a;
                                    steps   <= (op == op_pow) ? exponent : int_width'(1);
                                    state   <= s_mul;
                                end
                            end
                            op_div: begin
                                rem      <= pre_rem;
                                dividend <= {mag_a[number_width-frac_width-1:0],
                                             {frac_width{1'b0}}};
                                divisor  <= mag_b;
                                negate   <= a[number_width-1] ^ b[number_width-1];
                                steps    <= int_width'(number_width);
                                state    <= s_div;
                            end
                            default: begin
                                result <= '0;
                                done   <= 1'b1;
                            end
                        endcase
                    end
                end
                s_mul: begin
                    if (steps == int_width'(1)) begin
                        result <= product[frac_width +: number_width];
                        done   <= 1'b1;
                        state  <= s_idle;
                    end else begin
                        steps <= steps - 1'b1;
                        state <= s_pow;
                        quot  <= product[frac_width +: number_width];
                    end
                end
                s_pow: begin
                    product <= fixed_t'(quot) * base;
                    state   <= s_mul;
                end
                s_div: begin
                    rem      <= div_next[number_width-1:0];
                    quot     <= {quot[number_width-2:0], div_next[number_width]};
                    dividend <= dividend << 1;
                    steps    <= steps - 1'b1;
                    if (steps == int_width'(1)) begin
                        state <= s_div_fix;
                    end
                end
                s_div_fix: begin
                    // truncation toward zero on magnitudes
                    result <= negate ? -quot : quot;
                    done   <= 1'b1;
                    state  <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// File: stack_machine/stack_machine.sv
`timescale 1ns/1ps

module stack_machine import plot_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         start,
    input  col_t         x,
    input  queue_len_t   queue_length,
    input  logic         queue_ready,
    input  token_t       queue_data,
    output logic         ready,
    output row_t         row,
    output logic         skip,
    output logic         queue_get,
    output queue_index_t queue_index
);

    typedef enum logic [3:0] {
        s_idle,
        s_x_sub,
        s_x_div,
        s_fetch,
        s_wait_token,
        s_decode,
        s_op,
        s_y_start,
        s_y_mul,
        s_y_sub
    } state_t;

    state_t     state;
    queue_len_t tok_count;
    token_t     token;
    fixed_t     xf;

    fixed_t       stack [stack_size];
    stack_ptr_t   sp;
    stack_index_t top_idx;
    stack_index_t below_idx;
    logic         stack_we;
    stack_index_t stack_waddr;
    fixed_t       stack_wdata;

    logic   alu_start;
    op_t    alu_op;
    fixed_t alu_a;
    fixed_t alu_b;
    logic   alu_done;
    fixed_t alu_result;

    logic                 is_op;
    logic                 is_push;
    op_t                  opcode;
    logic [int_width-1:0] r_int;

    fixed_point_alu alu (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (alu_start),
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .done   (alu_done),
        .result (alu_result)
    );

    assign ready       = (state == s_idle);
    assign queue_index = queue_index_t'(tok_count);
    assign is_op       = token[number_width];
    assign opcode      = token[$bits(op_t)-1:0];
    assign is_push     = !is_op || opcode == op_var;
    assign top_idx     = stack_index_t'(sp) - 1'b1;
    assign below_idx   = stack_index_t'(sp) - 2'd2;
    assign r_int       = alu_result[number_width-1:frac_width];

    // push in decode, a result replaces the two operands
    always_comb begin
        stack_we    = 1'b0;
        stack_waddr = stack_index_t'(sp);
        stack_wdata = fixed_t'(token[number_width-1:0]);
        if (state == s_decode && is_push) begin
            stack_we = 1'b1;
            if (is_op) begin
                stack_wdata = xf;
            end
        end else if (state == s_op && alu_done) begin
            stack_we    = 1'b1;
            stack_waddr = below_idx;
            stack_wdata = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (stack_we) begin
            stack[stack_waddr] <= stack_wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= s_idle;
            tok_count <= '0;
            sp        <= '0;
            token     <= '0;
            xf        <= '0;
            row       <= '0;
            skip      <= 1'b0;
            queue_get <= 1'b0;
            alu_start <= 1'b0;
            alu_op    <= op_add;
            alu_a     <= '0;
            alu_b     <= '0;
        end else begin
            queue_get <= 1'b0;
            alu_start <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        row       <= '0;
                        skip      <= 1'b0;
                        tok_count <= '0;
                        sp        <= '0;
                        alu_op    <= op_sub;
                        alu_a     <= fixed_t'({x, {frac_width{1'b0}}});
                        alu_b     <= x_center;
                        alu_start <= 1'b1;
                        state     <= s_x_sub;
                    end
                end
                s_x_sub: begin
                    if (alu_done) begin
                        alu_op    <= op_div;
                        alu_a     <= alu_result;
                        alu_b     <= scale_fixed;
                        alu_start <= 1'b1;
                        state     <= s_x_div;
                    end
                end
                s_x_div: begin
                    if (alu_done) begin
                        xf    <= alu_result;
                        state <= s_fetch;
                    end
                end
                s_fetch: begin
                    if (tok_count >= queue_length) begin
                        state <= s_y_start;
                    end else begin
                        queue_get <= 1'b1;
                        state     <= s_wait_token;
                    end
                end
                s_wait_token: begin
                    if (queue_ready) begin
                        token     <= queue_data;
                        tok_count <= tok_count + 1'b1;
                        state     <= s_decode;
                    end
                end
                s_decode: begin
                    if (is_push) begin
                        sp    <= sp + 1'b1;
                        state <= s_fetch;
                    end else if (sp < stack_ptr_t'(2)) begin
                        // stack underflow, plot what is there
                        state <= s_y_start;
                    end else if (opcode == op_div && stack[top_idx] == '0) begin
                        skip  <= 1'b1;
                        state <= s_idle;
                    end else begin
                        alu_op    <= opcode;
                        alu_a     <= stack[below_idx];
                        alu_b     <= stack[top_idx];
                        alu_start <= 1'b1;
                        state     <= s_op;
                    end
                end
                s_op: begin
                    if (alu_done) begin
                        sp    <= sp - 1'b1;
                        state <= s_fetch;
                    end
                end
                s_y_start: begin
                    alu_op    <= op_mul;
                    alu_a     <= (sp != '0) ? stack[0] : '0;
                    alu_b     <= scale_fixed;
                    alu_start <= 1'b1;
                    state     <= s_y_mul;
                end
                s_y_mul: begin
                    if (alu_done) begin
                        alu_op    <= op_sub;
                        alu_a     <= y_center;
                        alu_b     <= alu_result;
                        alu_start <= 1'b1;
                        state     <= s_y_sub;
                    end
                end
                s_y_sub: begin
                    if (alu_done) begin
                        if (alu_result[number_width-1] || r_int >= ver_active) begin
                            skip <= 1'b1;
                        end else begin
                            row <= alu_result[frac_width +: $bits(row_t)];
                        end
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// File: tests/graph_column_tb.sv
`timescale 1ns/1ps

module graph_column_tb import plot_pkg::*; ();

    localparam int    clk_period     = 4;
    localparam int    reset_cycles   = 16;
    localparam int    cycles_per_col = 2000;
    localparam string test_file      = "tests/graph_column_tests.txt";

    logic   clk;
    logic   arst_n;
    logic   clear;
    logic   load_en;
    token_t load_data;
    logic   start;
    col_t   x;
    logic   ready;
    row_t   row;
    logic   skip;

    // one entry per record of the data file
    byte kind_q[$];
    int  value_q[$];
    int  row_q[$];
    int  skip_q[$];

    bit file_ok;
    bit file_loaded;
    int column_count;
    int row_errors;
    int skip_errors;
    int busy_errors;
    int state_errors;
    int format_errors;

    graph_column_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear),
        .load_en   (load_en),
        .load_data (load_data),
        .start     (start),
        .x         (x),
        .ready     (ready),
        .row       (row),
        .skip      (skip)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic read_tests();
        int    fd;
        string line;
        byte   kind;
        int    value;
        int    exp_row;
        int    exp_skip;
        int    fields;
        fd      = $fopen(test_file, "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            while ($fgets(line, fd) != 0) begin
                kind     = (line.len() > 0) ? line.getc(0) : 8'h00;
                value    = 0;
                exp_row  = 0;
                exp_skip = 0;
                fields   = 0;
                case (kind)
                    "C": fields = 1;
                    "T": fields = $sscanf(line, "T %h", value);
                    "X": begin
                        fields = $sscanf(line, "X %d %d %d", value, exp_row, exp_skip);
                        fields = (fields == 3) ? 1 : 0;
                    end
                    default: fields = -1;
                endcase
                if (fields == 1) begin
                    kind_q.push_back(kind);
                    value_q.push_back(value);
                    row_q.push_back(exp_row);
                    skip_q.push_back(exp_skip);
                    if (kind == "X") begin
                        column_count++;
                    end
                end else if (fields >= 0) begin
                    $display("malformed line in the test file: %s", line);
                    format_errors++;
                end
            end
            $fclose(fd);
            if (column_count == 0) begin
                $display("the test file holds no column records");
                format_errors++;
            end
        end
        file_loaded = 1'b1;
    endtask

    task automatic clear_queue();
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
    endtask

    task automatic load_token(input token_t tok);
        @(posedge clk);
        load_en   <= 1'b1;
        load_data <= tok;
        @(posedge clk);
        load_en   <= 1'b0;
    endtask

    task automatic plot_column(input int col, input int exp_row, input int exp_skip);
        @(posedge clk);
        start <= 1'b1;
        x     <= col_t'(col);
        @(posedge clk);
        start <= 1'b0;
        // outputs are sampled away from the active edge
        @(negedge clk);
        // an accepted start drops ready and clears the result
        assert (ready === 1'b0 && row === '0 && skip === 1'b0) else begin
            $display("Fail %0t: x %0d after start gave ready %b row %0d skip %b, expected 0 0 0",
                     $time, col, ready, row, skip);
            busy_errors++;
        end
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
        assert (skip === exp_skip[0]) else begin
            $display("Fail %0t: x %0d gave skip %b, expected %0d", $time, col, skip, exp_skip);
            skip_errors++;
        end
        assert (row === row_t'(exp_row)) else begin
            $display("Fail %0t: x %0d gave row %0d, expected %0d", $time, col, row, exp_row);
            row_errors++;
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        assert (ready === 1'b1 && row === '0 && skip === 1'b0) else begin
            $display("Fail %0t: after reset ready %b row %0d skip %b, expected 1 0 0",
                     $time, ready, row, skip);
            state_errors++;
        end
    endtask

    task automatic run_records();
        for (int i = 0; i < kind_q.size(); i++) begin
            case (kind_q[i])
                "C": clear_queue();
                "T": load_token(token_t'(value_q[i]));
                default: plot_column(value_q[i], row_q[i], skip_q[i]);
            endcase
        end
    endtask

    task automatic print_counts();
        $display("errors: row %0d, skip %0d, start %0d, reset state %0d, file format %0d",
                 row_errors, skip_errors, busy_errors, state_errors, format_errors);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        clear     = 1'b0;
        load_en   = 1'b0;
        load_data = '0;
        start     = 1'b0;
        x         = '0;
        read_tests();
        if (!file_ok) begin
            $display("could not open the test file %s", test_file);
            print_counts();
            $display("Test failed");
            $finish;
        end else begin
            repeat (reset_cycles) @(posedge clk);
            arst_n <= 1'b1;
            check_reset_state();
            run_records();
            print_counts();
            if (row_errors + skip_errors + busy_errors + state_errors
                    + format_errors == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // budget grows with the number of columns in the file
    initial begin
        wait (file_loaded);
        repeat ((column_count + 1) * cycles_per_col) @(posedge clk);
        $display("timeout: the DUT never returned to ready");
        print_counts();
        $display("Test failed");
        $finish;
    end

endmodule

// File: tests/graph_column_tests.txt
# C clears the queue; T loads one token, 21-bit hex (bit 20 flags an operator)
# X x_column expected_row expected_skip, all decimal
# empty program, f = 0
X 0 240 0
X 639 240 0
# constant 3.0
T 000300
X 100 180 0
X 500 180 0
# var alone, only right after a working clear
C
T 100006
X 340 220 0
X 300 260 0
X 333 227 0
X 307 252 0
# var var mul
C
T 100006
T 100006
T 100002
X 360 160 0
X 307 231 0
X 250 0 1
# var 2 pow
C
T 100006
T 000200
T 100004
X 333 231 0
X 300 220 0
# var 3 pow
C
T 100006
T 000300
T 100004
X 360 80 0
X 300 260 0
# var 0 pow gives 1.0
C
T 100006
T 000000
T 100004
X 123 220 0
# 1 var div
C
T 000100
T 100006
T 100003
X 320 0 1
X 340 220 0
X 360 230 0
X 325 160 0
X 300 260 0
# var 2 add, then var 1 sub
C
T 100006
T 000200
T 100000
X 340 180 0
C
T 100006
T 000100
T 100001
X 360 220 0
# off screen: 100, -20, -12; 12 lands on row 0
C
T 006400
X 10 0 1
C
T 0FEC00
X 10 0 1
C
T 0FF400
X 10 0 1
C
T 000C00
X 50 0 0
# 3 add 5 stops at the add and plots 3.0
C
T 000300
T 100000
T 000500
X 200 180 0
